// ==== Makefile ====
# Verilator simulation of the data cache directory

VERILATOR ?= verilator
TOP ?= dcache_dir_tb
FILELIST ?= dcache_dir.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dcache_dir.f ====
+incdir+hdl
hdl/dcache_dir_pkg.sv
hdl/dcache_valid.sv
hdl/dcache_tag_ram.sv
hdl/dcache_lookup.sv
hdl/dcache_plru.sv
hdl/dcache_dir.sv
dv/dcache_dir_assertions.sv
dv/dcache_dir_tb.sv

// ==== dv/dcache_dir_assertions.sv ====
// Concurrent checks on the lookup response of the directory
// Bound to the top level at the end of this file

`timescale 1ns/1ps

module dcache_dir_assertions (
	input logic clk,
	input logic rst,
	input logic lookup,
	input dcache_dir_pkg::lookup_rsp_t rsp
);

	// A lookup taken at one edge shows done after the following edge
	done_follows_lookup: assert property (@(posedge clk) disable iff (rst)
		lookup |-> ##2 rsp.done)
		else $error("rsp.done missing after a lookup");

	// No done pulse appears without a lookup behind it
	done_has_lookup: assert property (@(posedge clk) disable iff (rst)
		rsp.done |-> $past(lookup, 2))
		else $error("rsp.done without a matching lookup");

	// Reset quiets the response on the next edge
	quiet_in_reset: assert property (@(posedge clk)
		rst |=> (!rsp.done && !rsp.hit))
		else $error("rsp.done or rsp.hit high during reset");

	hit_needs_done: assert property (@(posedge clk) disable iff (rst)
		rsp.hit |-> rsp.done)
		else $error("rsp.hit without rsp.done");

endmodule

bind dcache_dir dcache_dir_assertions u_assertions (
	.clk(clk),
	.rst(rst),
	.lookup(lookup),
	.rsp(rsp)
);

// ==== dv/dcache_dir_tb.sv ====
// Testbench for the data cache directory
// Directed tests for fill, lookup and invalidate, then a random mix
// Reference model of valid, tag and pseudo-LRU state with a compare process

`timescale 1ns/1ps

`include "dcache_dir_macros.svh"

module dcache_dir_tb;
	import dcache_dir_pkg::*;

	localparam int RESET_CYCLES = 8;
	localparam int RAND_CYCLES = 400;
	// About 32 lookups of three cycles each plus single fill and invalidate cycles
	localparam int DIRECTED_CYCLES = 120;
	localparam int CYCLE_LIMIT = 2 * (RESET_CYCLES + DIRECTED_CYCLES + RAND_CYCLES + 4);
	localparam fill_req_t NO_FILL = '0;
	localparam inv_req_t NO_INV = '0;

	logic clk;
	logic rst;
	fill_req_t fill;
	inv_req_t inv;
	logic lookup;
	pa_t lookup_adr;
	lookup_rsp_t rsp;
	way_t victim_way;

	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int errors_before = 0;
	int cycles;
	logic [31:0] rng_state = 32'd6;

	// Reference state, updated at each rising edge from the inputs seen there
	logic ref_valid [`DCD_WAYS][`DCD_LINES];
	tag_t ref_tags [`DCD_WAYS][`DCD_LINES];
	plru_t ref_plru [`DCD_LINES];
	lookup_rsp_t pipe_rsp;
	lookup_rsp_t exp_rsp;
	line_idx_t pipe_idx;
	line_idx_t exp_idx;

	dcache_dir DUT (
		.clk(clk),
		.rst(rst),
		.fill(fill),
		.inv(inv),
		.lookup(lookup),
		.lookup_adr(lookup_adr),
		.rsp(rsp),
		.victim_way(victim_way)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ======================================================================
	// Address helpers and reference functions
	// ======================================================================

	function automatic logic [31:0] xorshift();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	function automatic line_idx_t idx_of(input pa_t a);
		return a[`DCD_IDX_LSB +: `DCD_IDX_BITS];
	endfunction

	function automatic tag_t tag_of(input pa_t a);
		return a[`DCD_AWID-1:`DCD_TAG_LSB];
	endfunction

	function automatic pa_t make_adr(input tag_t t, input line_idx_t i);
		return {t, i, {`DCD_IDX_LSB{1'b0}}};
	endfunction

	// Eight tags over four lines, so random traffic collides often
	function automatic pa_t rand_adr(input logic [7:0] s);
		return make_adr(tag_t'(s[2:0]), line_idx_t'(s[4:3]));
	endfunction

	// Turn the root and the pair bit away from the way just used
	function automatic plru_t ref_touch(input plru_t cur, input way_t w);
		plru_t nxt;
		nxt = cur;
		if (w < 2'd2) begin
			nxt[0] = 1'b1;
			nxt[1] = (w == 2'd0);
		end else begin
			nxt[0] = 1'b0;
			nxt[2] = (w == 2'd2);
		end
		return nxt;
	endfunction

	function automatic way_t ref_victim(input line_idx_t i);
		if (!ref_plru[i][0])
			return ref_plru[i][1] ? 2'd1 : 2'd0;
		return ref_plru[i][2] ? 2'd3 : 2'd2;
	endfunction

	// Lowest valid way whose tag matches wins
	function automatic lookup_rsp_t ref_lookup(input pa_t adr);
		lookup_rsp_t res;
		res = '0;
		res.done = 1'b1;
		for (int w = 0; w < `DCD_WAYS; w++) begin
			if (!res.hit && ref_valid[w][idx_of(adr)] &&
					ref_tags[w][idx_of(adr)] == tag_of(adr)) begin
				res.hit = 1'b1;
				res.way = way_t'(w);
			end
		end
		return res;
	endfunction

	// ======================================================================
	// Reference model and compare
	// ======================================================================

	always @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `DCD_LINES; i++) begin
				ref_plru[i] = '0;
				for (int w = 0; w < `DCD_WAYS; w++)
					ref_valid[w][i] = 1'b0;
			end
			pipe_rsp = '0;
			exp_rsp = '0;
		end else begin
			// The response shown before this edge ages its line unless a fill hits that line
			if (exp_rsp.hit && !(fill.wr && idx_of(fill.dadr) == exp_idx))
				ref_plru[exp_idx] = ref_touch(ref_plru[exp_idx], exp_rsp.way);
			exp_rsp = pipe_rsp;
			exp_idx = pipe_idx;
			// Lookup sees the state from before this edge's fill or invalidate
			pipe_rsp = lookup ? ref_lookup(lookup_adr) : '0;
			pipe_idx = idx_of(lookup_adr);
			if (fill.wr) begin
				ref_valid[fill.way][idx_of(fill.dadr)] = 1'b1;
				ref_tags[fill.way][idx_of(fill.dadr)] = tag_of(fill.dadr);
				ref_plru[idx_of(fill.dadr)] = ref_touch(ref_plru[idx_of(fill.dadr)], fill.way);
			end else if (inv.invce) begin
				for (int i = 0; i < `DCD_LINES; i++)
					for (int w = 0; w < `DCD_WAYS; w++)
						if (inv.invline ? (line_idx_t'(i) == idx_of(inv.adr)) : inv.invall)
							ref_valid[w][i] = 1'b0;
			end
		end
	end

	task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	// Outputs are settled at the falling edge
	always @(negedge clk) begin
		if (!rst) begin
			check_val("rsp.done", 32'(rsp.done), 32'(exp_rsp.done));
			if (exp_rsp.done) begin
				check_val("rsp.hit", 32'(rsp.hit), 32'(exp_rsp.hit));
				if (exp_rsp.hit)
					check_val("rsp.way", 32'(rsp.way), 32'(exp_rsp.way));
			end
			check_val("victim_way", 32'(victim_way), 32'(ref_victim(idx_of(fill.dadr))));
		end
	end

	// ======================================================================
	// Stimulus tasks
	// ======================================================================

	task automatic drive(input fill_req_t f, input inv_req_t i, input logic lk, input pa_t la);
		@(posedge clk);
		fill <= f;
		inv <= i;
		lookup <= lk;
		lookup_adr <= la;
	endtask

	task automatic do_fill(input pa_t adr, input way_t w);
		drive(fill_req_t'{wr: 1'b1, dadr: adr, way: w}, NO_INV, 1'b0, '0);
	endtask

	task automatic do_inv(input logic line, input logic all, input pa_t adr);
		drive(NO_FILL, inv_req_t'{invce: 1'b1, invline: line, invall: all, adr: adr}, 1'b0, '0);
	endtask

	// One lookup, optionally beside a fill, then wait for done and check it
	task automatic probe(input fill_req_t f, input pa_t adr, input logic exp_hit,
			input way_t exp_way);
		int waited;
		waited = 0;
		drive(f, NO_INV, 1'b1, adr);
		f.wr = 1'b0;
		drive(f, NO_INV, 1'b0, '0);
		@(negedge clk);
		while (!rsp.done && waited < 4) begin
			@(negedge clk);
			waited++;
		end
		if (!rsp.done) begin
			errors++;
			$display("Lookup of %h at %0t got no done within 4 cycles", adr, $time);
		end else begin
			check_val("lookup hit", 32'(rsp.hit), 32'(exp_hit));
			if (exp_hit)
				check_val("lookup way", 32'(rsp.way), 32'(exp_way));
		end
	endtask

	task automatic report(input string name);
		tests_run++;
		$display("test %0d %s: %s, %0d errors", tests_run, name,
			(errors == errors_before) ? "ok" : "failed", errors - errors_before);
		errors_before = errors;
	endtask

	// ======================================================================
	// Test sequence
	// ======================================================================

	initial begin
		logic [31:0] r;
		pa_t a;
		pa_t b;
		pa_t cur;
		way_t v;
		fill_req_t nf;
		inv_req_t ni;
		rst = 1'b1;
		fill = NO_FILL;
		inv = NO_INV;
		lookup = 1'b0;
		lookup_adr = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;

		for (int n = 0; n < 16; n++) begin
			r = xorshift();
			probe(fill_req_t'{wr: 1'b0, dadr: pa_t'(r), way: 2'd0}, pa_t'(r), 1'b0, 2'd0);
			check_val("victim after reset", 32'(victim_way), 32'd0);
		end
		report("reset state");

		a = make_adr(18'h1234, 7'd5);
		do_fill(a, 2'd2);
		probe(NO_FILL, a, 1'b1, 2'd2);
		probe(NO_FILL, make_adr(18'h1235, 7'd5), 1'b0, 2'd0);
		report("fill then lookup");

		for (int w = 0; w < `DCD_WAYS; w++)
			do_fill(make_adr(tag_t'(w + 16), 7'd9), way_t'(w));
		b = make_adr(18'h77, 7'd10);
		do_fill(b, 2'd1);
		do_inv(1'b1, 1'b0, make_adr(18'h0, 7'd9));
		for (int w = 0; w < `DCD_WAYS; w++)
			probe(NO_FILL, make_adr(tag_t'(w + 16), 7'd9), 1'b0, 2'd0);
		probe(NO_FILL, b, 1'b1, 2'd1);
		// A single line beats a whole-cache invalidate in the same request
		do_fill(make_adr(18'd16, 7'd9), 2'd0);
		do_inv(1'b1, 1'b1, make_adr(18'h0, 7'd9));
		probe(NO_FILL, make_adr(18'd16, 7'd9), 1'b0, 2'd0);
		probe(NO_FILL, b, 1'b1, 2'd1);
		report("line invalidate");

		do_inv(1'b0, 1'b1, '0);
		probe(NO_FILL, a, 1'b0, 2'd0);
		probe(NO_FILL, b, 1'b0, 2'd0);
		report("invalidate all");

		a = make_adr(18'h2aa, 7'd33);
		drive(fill_req_t'{wr: 1'b1, dadr: a, way: 2'd3},
			inv_req_t'{invce: 1'b1, invline: 1'b1, invall: 1'b1, adr: a}, 1'b0, '0);
		probe(NO_FILL, a, 1'b1, 2'd3);
		b = make_adr(18'h155, 7'd34);
		probe(fill_req_t'{wr: 1'b1, dadr: b, way: 2'd1}, b, 1'b0, 2'd0);
		probe(NO_FILL, b, 1'b1, 2'd1);
		report("same-cycle priority");

		for (int n = 0; n < RAND_CYCLES; n++) begin
			@(negedge clk);
			// The pending address is already on dadr, so victim_way names its victim
			v = victim_way;
			cur = fill.dadr;
			r = xorshift();
			nf = fill_req_t'{wr: 1'b0, dadr: rand_adr(r[23:16]), way: 2'd0};
			ni = NO_INV;
			if (r[3:0] < 4'd5)
				nf = fill_req_t'{wr: 1'b1, dadr: cur, way: v};
			else if (r[3:0] > 4'd12)
				ni = inv_req_t'{invce: 1'b1, invline: r[3:0] != 4'd15, invall: r[5],
					adr: rand_adr(r[31:24])};
			drive(nf, ni, r[4], rand_adr(r[15:8]));
		end
		drive(NO_FILL, NO_INV, 1'b0, '0);
		repeat (3) @(negedge clk);
		report("random mix");

		$display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== hdl/dcache_dir.sv ====
// Top level of the four-way data cache directory
// Valid array, tag RAM, lookup pipeline and pseudo-LRU replacement

`timescale 1ns/1ps

`include "dcache_dir_macros.svh"

module dcache_dir (
	input logic clk,
	input logic rst,
	input dcache_dir_pkg::fill_req_t fill,
	input dcache_dir_pkg::inv_req_t inv,
	input logic lookup,
	input dcache_dir_pkg::pa_t lookup_adr,
	output dcache_dir_pkg::lookup_rsp_t rsp,
	output dcache_dir_pkg::way_t victim_way
);
	import dcache_dir_pkg::*;

	// Valid mask and tags of the line being looked up
	way_mask_t rd_valid;
	tag_t [`DCD_WAYS-1:0] rd_tags;
	// Line of the current response, for the replacement update
	line_idx_t rsp_idx;
	line_idx_t lookup_idx;

	assign lookup_idx = lookup_adr[`DCD_IDX_LSB +: `DCD_IDX_BITS];

	// ======================================================================
	// Storage
	// ======================================================================

	dcache_valid u_valid (
		.clk(clk),
		.rst(rst),
		.fill(fill),
		.inv(inv),
		.rd_idx(lookup_idx),
		.rd_valid(rd_valid)
	);

	dcache_tag_ram u_tag_ram (
		.clk(clk),
		.fill(fill),
		.rd_idx(lookup_idx),
		.rd_tags(rd_tags)
	);

	// ======================================================================
	// Lookup and replacement
	// ======================================================================

	dcache_lookup u_lookup (
		.clk(clk),
		.rst(rst),
		.lookup(lookup),
		.lookup_adr(lookup_adr),
		.rd_valid(rd_valid),
		.rd_tags(rd_tags),
		.rsp(rsp),
		.rsp_idx(rsp_idx)
	);

	// Hits come back from the response to age the line
	dcache_plru u_plru (
		.clk(clk),
		.rst(rst),
		.fill(fill),
		.rsp(rsp),
		.rsp_idx(rsp_idx),
		.victim_way(victim_way)
	);

endmodule

// ==== hdl/dcache_dir_macros.svh ====
// Geometry macros for the data cache directory
// Four ways of 128 lines, 128-byte lines, 32-bit physical address

`ifndef DCACHE_DIR_MACROS_SVH
`define DCACHE_DIR_MACROS_SVH

// Lines held in each way
`define DCD_LINES 128
// Associativity of the cache
`define DCD_WAYS 4
// Physical address width
`define DCD_AWID 32

// The line index sits just above the 128-byte line offset
`define DCD_IDX_LSB 7
`define DCD_IDX_BITS 7
// Everything above the index is tag
`define DCD_TAG_LSB 14

`endif

// ==== hdl/dcache_dir_pkg.sv ====
// Shared types for the data cache directory
// Vector typedefs for addresses, indexes, tags and ways
// Packed request and response structs

`include "dcache_dir_macros.svh"

package dcache_dir_pkg;

	typedef logic [`DCD_AWID-1:0] pa_t;
	typedef logic [`DCD_IDX_BITS-1:0] line_idx_t;
	typedef logic [`DCD_AWID-`DCD_TAG_LSB-1:0] tag_t;
	typedef logic [$clog2(`DCD_WAYS)-1:0] way_t;
	typedef logic [`DCD_WAYS-1:0] way_mask_t;
	// A binary tree over four ways needs three node bits
	typedef logic [`DCD_WAYS-2:0] plru_t;

	// Line fill, the way is picked outside the directory
	typedef struct packed {
		logic wr;
		pa_t dadr;
		way_t way;
	} fill_req_t;

	// Invalidate of one line in all ways or of the whole cache
	typedef struct packed {
		logic invce;
		logic invline;
		logic invall;
		pa_t adr;
	} inv_req_t;

	typedef struct packed {
		logic done;
		logic hit;
		way_t way;
	} lookup_rsp_t;

endpackage

// ==== hdl/dcache_lookup.sv ====
// Lookup pipeline of the data cache directory
// Registers the request, compares the tags of all ways
// Registers the hit and the hit way as the response

`timescale 1ns/1ps

`include "dcache_dir_macros.svh"

module dcache_lookup (
	input logic clk,
	input logic rst,
	input logic lookup,
	input dcache_dir_pkg::pa_t lookup_adr,
	input dcache_dir_pkg::way_mask_t rd_valid,
	input dcache_dir_pkg::tag_t [`DCD_WAYS-1:0] rd_tags,
	output dcache_dir_pkg::lookup_rsp_t rsp,
	output dcache_dir_pkg::line_idx_t rsp_idx
);
	import dcache_dir_pkg::*;

	// ======================================================================
	// Request stage, aligned with the registered tag RAM output
	// ======================================================================

	logic lookup_q;
	line_idx_t idx_q;
	tag_t tag_q;
	way_mask_t valid_q;

	always_ff @(posedge clk) begin
		if (rst)
			lookup_q <= 1'b0;
		else
			lookup_q <= lookup;
		idx_q <= lookup_adr[`DCD_IDX_LSB +: `DCD_IDX_BITS];
		tag_q <= lookup_adr[`DCD_AWID-1:`DCD_TAG_LSB];
		valid_q <= rd_valid;
	end

	// ======================================================================
	// Compare and response stage
	// ======================================================================

	way_mask_t match;
	way_t hit_way;

	// Scanning downward leaves the lowest matching way in hit_way
	// Two matches only happen when the same tag was filled twice
	always_comb begin
		hit_way = '0;
		for (int w = `DCD_WAYS - 1; w >= 0; w--) begin
			match[w] = valid_q[w] && (rd_tags[w] == tag_q);
			if (match[w])
				hit_way = way_t'(w);
		end
	end

	// Done lasts one cycle per lookup, hit never rises without it
	always_ff @(posedge clk) begin
		if (rst) begin
			rsp.done <= 1'b0;
			rsp.hit <= 1'b0;
		end else begin
			rsp.done <= lookup_q;
			rsp.hit <= lookup_q && (|match);
		end
		rsp.way <= hit_way;
		rsp_idx <= idx_q;
	end

endmodule

// ==== hdl/dcache_plru.sv ====
// Tree pseudo-LRU state of the data cache directory
// Three node bits per line, updated on hits and fills
// Victim way decode for the line of the fill address

`timescale 1ns/1ps

`include "dcache_dir_macros.svh"

module dcache_plru (
	input logic clk,
	input logic rst,
	input dcache_dir_pkg::fill_req_t fill,
	input dcache_dir_pkg::lookup_rsp_t rsp,
	input dcache_dir_pkg::line_idx_t rsp_idx,
	output dcache_dir_pkg::way_t victim_way
);
	import dcache_dir_pkg::*;

	plru_t bits [`DCD_LINES];

	line_idx_t fill_idx;
	logic hit_upd;

	assign fill_idx = fill.dadr[`DCD_IDX_LSB +: `DCD_IDX_BITS];

	// A fill to the same line in this cycle overrides the hit update
	assign hit_upd = rsp.done && rsp.hit && !(fill.wr && (fill_idx == rsp_idx));

	// Node 0 picks the half, node 1 the low pair, node 2 the high pair
	// An access turns the root and its own pair node away from the way
	function automatic plru_t touch(input plru_t cur, input way_t w);
		plru_t nxt;
		nxt = cur;
		nxt[0] = ~w[1];
		if (w[1])
			nxt[2] = ~w[0];
		else
			nxt[1] = ~w[0];
		return nxt;
	endfunction

	// ======================================================================
	// State update
	// ======================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `DCD_LINES; i++)
				bits[i] <= '0;
		end else begin
			if (hit_upd)
				bits[rsp_idx] <= touch(bits[rsp_idx], rsp.way);
			if (fill.wr)
				bits[fill_idx] <= touch(bits[fill_idx], fill.way);
		end
	end

	// ======================================================================
	// Victim decode
	// ======================================================================

	// Follow the tree from the root down to a leaf
	always_comb begin
		if (bits[fill_idx][0])
			victim_way = {1'b1, bits[fill_idx][2]};
		else
			victim_way = {1'b0, bits[fill_idx][1]};
	end

endmodule

// ==== hdl/dcache_tag_ram.sv ====
// Tag storage of the data cache directory
// One 128-entry RAM per way, written by fills, read on every cycle

`timescale 1ns/1ps

`include "dcache_dir_macros.svh"

module dcache_tag_ram (
	input logic clk,
	input dcache_dir_pkg::fill_req_t fill,
	input dcache_dir_pkg::line_idx_t rd_idx,
	output dcache_dir_pkg::tag_t [`DCD_WAYS-1:0] rd_tags
);
	import dcache_dir_pkg::*;

	line_idx_t fill_idx;
	tag_t fill_tag;

	assign fill_idx = fill.dadr[`DCD_IDX_LSB +: `DCD_IDX_BITS];
	assign fill_tag = fill.dadr[`DCD_AWID-1:`DCD_TAG_LSB];

	// Every way gets its own RAM so each maps onto a separate block
	for (genvar w = 0; w < `DCD_WAYS; w++) begin : g_way
		tag_t mem [`DCD_LINES];
		tag_t rd_q;
		logic we;

		// Only the way named by the fill is written
		assign we = fill.wr && (fill.way == way_t'(w));

		// Read and write share the edge
		// The nonblocking read returns the old tag when both hit one entry
		always_ff @(posedge clk) begin
			if (we)
				mem[fill_idx] <= fill_tag;
			rd_q <= mem[rd_idx];
		end

		assign rd_tags[w] = rd_q;
	end

endmodule

// ==== hdl/dcache_valid.sv ====
// Valid bit array of the data cache directory
// One bit per way and line, set by fills and cleared by invalidates

`timescale 1ns/1ps

`include "dcache_dir_macros.svh"

module dcache_valid (
	input logic clk,
	input logic rst,
	input dcache_dir_pkg::fill_req_t fill,
	input dcache_dir_pkg::inv_req_t inv,
	input dcache_dir_pkg::line_idx_t rd_idx,
	output dcache_dir_pkg::way_mask_t rd_valid
);
	import dcache_dir_pkg::*;

	// One row of line bits for every way
	logic [`DCD_LINES-1:0] valid [`DCD_WAYS];

	line_idx_t fill_idx;
	line_idx_t inv_idx;

	assign fill_idx = fill.dadr[`DCD_IDX_LSB +: `DCD_IDX_BITS];
	assign inv_idx = inv.adr[`DCD_IDX_LSB +: `DCD_IDX_BITS];

	// ======================================================================
	// Update
	// ======================================================================

	// A fill wins over any invalidate in the same cycle
	// Within an invalidate a single line wins over the whole cache
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < `DCD_WAYS; w++)
				valid[w] <= '0;
		end else if (fill.wr) begin
			valid[fill.way][fill_idx] <= 1'b1;
		end else if (inv.invce) begin
			for (int w = 0; w < `DCD_WAYS; w++) begin
				if (inv.invline)
					valid[w][inv_idx] <= 1'b0;
				else if (inv.invall)
					valid[w] <= '0;
			end
		end
	end

	// ======================================================================
	// Read port
	// ======================================================================

	// The mask is taken before this edge's update, so a lookup sampling
	// it together with a fill still sees the old state
	always_comb begin
		for (int w = 0; w < `DCD_WAYS; w++)
			rd_valid[w] = valid[w][rd_idx];
	end

endmodule
